/* msx_slot_system.f */
src/msx_pkg.sv
src/slot_decoder.sv
src/block_mapper.sv
src/mem_arbiter.sv
src/ram_store.sv
src/msx_slot_system.sv
tests/msx_slot_system_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds and runs the slot system testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   --top-module msx_slot_system_tb \
   -f msx_slot_system.f

# The simulation exits nonzero on failure, so keep its output for the search below
output=$(./obj_dir/Vmsx_slot_system_tb) || true
echo "$output"

if grep -q "all tests passed" <<< "$output"; then
   exit 0
else
   echo "simulation did not report success"
   exit 1
fi

/* tests/msx_slot_system_tb.sv */
`timescale 1ns/1ps

module msx_slot_system_tb;

   localparam int ADDR_W = 20;
   localparam int BASE_W = ADDR_W - msx_pkg::PAGE_OFFSET_W;
   localparam logic [BASE_W-1:0] SCRATCH_BASE = BASE_W'(50);  // Loader stream target, never read

   typedef enum logic [2:0] {
      OP_LAYOUT, OP_LOAD, OP_EXPANDER, OP_IO_WR, OP_IO_RD, OP_MEM_WR, OP_MEM_RD, OP_STREAM_RD
   } op_t;

   typedef struct packed {
      op_t                  op;
      logic [ADDR_W-1:0]    addr;            // CPU address, load address or layout index
      logic [7:0]           data;            // Write data, base page or expander bits
      msx_pkg::block_kind_t kind;
      logic [7:0]           exp_data;
   } op_entry_t;

   logic                 clk;
   logic                 clk_ce;
   logic                 reset;
   logic [15:0]          cpu_addr;
   logic [7:0]           cpu_dout;
   logic                 cpu_mreq;
   logic                 cpu_iorq;
   logic                 cpu_wr;
   logic [7:0]           cpu_din;
   logic                 cpu_ready;
   logic [ADDR_W-1:0]    load_addr;
   logic [7:0]           load_data;
   logic                 load_req;
   logic                 load_done;
   logic                 layout_we;
   logic [5:0]           layout_index;
   msx_pkg::block_kind_t layout_kind;
   logic [BASE_W-1:0]    layout_base;
   logic [3:0]           expander_present;

   op_entry_t            ops [$];
   int                   seed;
   int                   cycle_count;
   logic [7:0]           got;

   // Reference model of the slot rules
   logic [7:0]           model_slot;
   logic [7:0]           model_sub [4];
   logic [3:0]           model_exp;
   msx_pkg::block_kind_t model_kind [msx_pkg::LAYOUT_ENTRIES];
   logic [BASE_W-1:0]    model_base [msx_pkg::LAYOUT_ENTRIES];
   logic [7:0]           model_mem [2**ADDR_W];

   msx_slot_system #(.ADDR_W(ADDR_W)) u_dut (
      .clk              (clk),
      .clk_ce           (clk_ce),
      .reset            (reset),
      .cpu_addr         (cpu_addr),
      .cpu_dout         (cpu_dout),
      .cpu_mreq         (cpu_mreq),
      .cpu_iorq         (cpu_iorq),
      .cpu_wr           (cpu_wr),
      .cpu_din          (cpu_din),
      .cpu_ready        (cpu_ready),
      .load_addr        (load_addr),
      .load_data        (load_data),
      .load_req         (load_req),
      .load_done        (load_done),
      .layout_we        (layout_we),
      .layout_index     (layout_index),
      .layout_kind      (layout_kind),
      .layout_base      (layout_base),
      .expander_present (expander_present)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Budget grows with the table, which is built at time zero
   initial begin
      cycle_count = 0;
      while (cycle_count < 10 + 30 * ops.size()) begin
         @(posedge clk);
         cycle_count++;
      end
      $display("timeout: the DUT gave no ready or done pulse within %0d cycles", cycle_count);
      $display("tests failed");
      $fatal(1, "run stopped by the cycle limit");
   end

   function automatic int index_of(input int slot, input int sub, input int page);
      return slot * 16 + sub * 4 + page;
   endfunction

   function automatic logic [5:0] entry_of(input logic [15:0] a);
      logic [1:0] page;
      logic [1:0] slot;
      logic [1:0] sub;
      page = a[15:14];
      slot = model_slot[2*page +: 2];
      sub  = model_exp[slot] ? model_sub[slot][2*page +: 2] : 2'd0;
      return {slot, sub, page};
   endfunction

   function automatic bit subslot_hit(input logic [15:0] a);
      return (a == 16'hFFFF) && model_exp[model_slot[7:6]];
   endfunction

   function automatic logic [7:0] model_read(input logic io, input logic [15:0] a);
      logic [5:0] e;
      e = entry_of(a);
      if (io)
         return (a[7:0] == 8'hA8) ? model_slot : 8'hFF;
      if (subslot_hit(a))
         return ~model_sub[model_slot[7:6]];
      if (model_kind[e] == msx_pkg::BLOCK_NONE)
         return 8'hFF;
      return model_mem[{model_base[e], a[13:0]}];
   endfunction

   function automatic void model_write(input logic io, input logic [15:0] a, input logic [7:0] d);
      logic [5:0] e;
      e = entry_of(a);
      if (io) begin
         if (a[7:0] == 8'hA8)
            model_slot = d;
      end else if (subslot_hit(a)) begin
         model_sub[model_slot[7:6]] = d;
      end else if (model_kind[e] == msx_pkg::BLOCK_RAM) begin
         model_mem[{model_base[e], a[13:0]}] = d;       // ROM and empty blocks ignore writes
      end
   endfunction

   task automatic add_op(input op_t op, input int addr, input int data,
                         input msx_pkg::block_kind_t kind = msx_pkg::BLOCK_NONE);
      op_entry_t e;
      int        rnd;
      logic      io;
      e.op       = op;
      e.addr     = addr[ADDR_W-1:0];
      e.data     = data[7:0];
      e.kind     = kind;
      e.exp_data = 8'h00;
      io         = (op == OP_IO_WR) || (op == OP_IO_RD);
      case (op)
         OP_LAYOUT: begin
            model_kind[addr[5:0]] = kind;
            model_base[addr[5:0]] = data[BASE_W-1:0];
         end
         OP_LOAD: begin
            rnd                = $random(seed);
            e.data             = rnd[7:0];
            model_mem[e.addr]  = e.data;
         end
         OP_EXPANDER:         model_exp = data[3:0];
         OP_IO_WR, OP_MEM_WR: model_write(io, e.addr[15:0], e.data);
         default:             e.exp_data = model_read(io, e.addr[15:0]);
      endcase
      ops.push_back(e);
   endtask

   task automatic check_value(input string name, input logic [7:0] actual, input logic [7:0] want);
      if (actual !== want) begin
         $display("error: time %0t, %s = %h, expected %h", $time, name, actual, want);
         $display("tests failed");
         $fatal(1, "stopped at the first mismatch");
      end
   endtask

   task automatic write_layout(input logic [5:0] idx, input msx_pkg::block_kind_t kind,
                               input logic [BASE_W-1:0] base);
      @(negedge clk);
      layout_we    = 1'b1;
      layout_index = idx;
      layout_kind  = kind;
      layout_base  = base;
      @(negedge clk);
      layout_we    = 1'b0;
   endtask

   task automatic load_byte(input logic [ADDR_W-1:0] addr, input logic [7:0] data);
      @(negedge clk);
      load_addr = addr;
      load_data = data;
      load_req  = 1'b1;
      @(negedge clk);
      while (!load_done)
         @(negedge clk);
      @(negedge clk);
      load_req  = 1'b0;                     // Dropped the cycle after load_done
   endtask

   task automatic load_stream(input int count);
      int rnd;
      for (int k = 0; k < count; k++) begin
         rnd = $random(seed);
         load_byte({SCRATCH_BASE, rnd[13:0]}, rnd[21:14]);
      end
   endtask

   task automatic cpu_access(input op_entry_t e, output logic [7:0] rdata);
      logic io;
      logic wr;
      io = e.op inside {OP_IO_WR, OP_IO_RD};
      wr = e.op inside {OP_IO_WR, OP_MEM_WR};
      @(negedge clk);
      cpu_addr = e.addr[15:0];
      cpu_dout = e.data;
      cpu_iorq = io;
      cpu_mreq = !io;
      cpu_wr   = wr;
      @(negedge clk);
      cpu_iorq = 1'b0;                     // Strobe lasts one cycle, address is held
      cpu_mreq = 1'b0;
      cpu_wr   = 1'b0;
      if (io)
         check_value("cpu_ready", {7'd0, cpu_ready}, 8'h01);
      while (!cpu_ready)
         @(negedge clk);
      rdata = cpu_din;
   endtask

   initial begin
      clk_ce           = 1'b1;
      reset            = 1'b1;
      cpu_addr         = 16'h0000;
      cpu_dout         = 8'h00;
      cpu_mreq         = 1'b0;
      cpu_iorq         = 1'b0;
      cpu_wr           = 1'b0;
      load_addr        = '0;
      load_data        = 8'h00;
      load_req         = 1'b0;
      layout_we        = 1'b0;
      layout_index     = 6'd0;
      layout_kind      = msx_pkg::BLOCK_NONE;
      layout_base      = '0;
      expander_present = 4'h0;
      seed             = 58;
      got              = 8'h00;
      model_slot       = 8'h00;
      model_exp        = 4'h0;
      for (int s = 0; s < 4; s++)
         model_sub[s] = 8'h00;
      for (int n = 0; n < msx_pkg::LAYOUT_ENTRIES; n++) begin
         model_kind[n] = msx_pkg::BLOCK_NONE;
         model_base[n] = '0;
      end

      add_op(OP_IO_RD, 'hA8, 0);
      add_op(OP_MEM_RD, 'h1234, 0);                   // Empty layout
      add_op(OP_LAYOUT, index_of(0, 0, 0), 1, msx_pkg::BLOCK_ROM);
      add_op(OP_LAYOUT, index_of(1, 0, 0), 2, msx_pkg::BLOCK_ROM);
      add_op(OP_LAYOUT, index_of(2, 0, 1), 8, msx_pkg::BLOCK_RAM);
      add_op(OP_LAYOUT, index_of(3, 0, 1), 9, msx_pkg::BLOCK_RAM);
      add_op(OP_LAYOUT, index_of(2, 1, 1), 10, msx_pkg::BLOCK_RAM);
      add_op(OP_LAYOUT, index_of(2, 0, 3), 11, msx_pkg::BLOCK_RAM);
      add_op(OP_LOAD, 'h04010, 0);                    // ROM images at base pages 1 and 2
      add_op(OP_LOAD, 'h04011, 0);
      add_op(OP_LOAD, 'h08010, 0);
      add_op(OP_MEM_RD, 'h0010, 0);
      add_op(OP_MEM_RD, 'h0011, 0);
      add_op(OP_MEM_WR, 'h0010, 'h5A);                // Write into ROM
      add_op(OP_MEM_RD, 'h0010, 0);
      add_op(OP_IO_WR, 'hA8, 'h01);
      add_op(OP_IO_RD, 'hA8, 0);
      add_op(OP_MEM_RD, 'h0010, 0);
      add_op(OP_IO_WR, 'hA8, 'h08);                   // Page 1 from slot 2
      add_op(OP_MEM_WR, 'h4020, 'h11);
      add_op(OP_MEM_WR, 'h4021, 'h22);
      add_op(OP_IO_WR, 'hA8, 'h0C);                   // Page 1 from slot 3
      add_op(OP_MEM_WR, 'h4020, 'h33);
      add_op(OP_MEM_RD, 'h4020, 0);
      add_op(OP_IO_WR, 'hA8, 'h08);
      add_op(OP_MEM_RD, 'h4020, 0);
      add_op(OP_MEM_RD, 'h4021, 0);
      add_op(OP_IO_WR, 'hA8, 'h88);                   // Page 3 also from slot 2
      add_op(OP_MEM_WR, 'hFFFF, 'h44);
      add_op(OP_MEM_RD, 'hFFFF, 0);
      add_op(OP_EXPANDER, 0, 'h4);
      add_op(OP_MEM_RD, 'hFFFF, 0);
      add_op(OP_MEM_WR, 'hFFFF, 'h04);                // Subslot 1 on page 1
      add_op(OP_MEM_RD, 'hFFFF, 0);
      add_op(OP_MEM_WR, 'h4020, 'h66);
      add_op(OP_MEM_RD, 'h4020, 0);
      add_op(OP_MEM_WR, 'hFFFF, 'h00);
      add_op(OP_MEM_RD, 'h4020, 0);
      add_op(OP_EXPANDER, 0, 0);
      add_op(OP_MEM_RD, 'hFFFF, 0);
      add_op(OP_STREAM_RD, 'h0010, 0);                // Reads against a busy loader
      add_op(OP_STREAM_RD, 'h0011, 0);
      add_op(OP_STREAM_RD, 'h4021, 0);

      repeat (10) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      repeat (3) begin
         @(negedge clk);
         check_value("cpu_ready", {7'd0, cpu_ready}, 8'h00);
         check_value("load_done", {7'd0, load_done}, 8'h00);
      end

      foreach (ops[i]) begin
         case (ops[i].op)
            OP_LAYOUT:   write_layout(ops[i].addr[5:0], ops[i].kind, ops[i].data[BASE_W-1:0]);
            OP_LOAD:     load_byte(ops[i].addr, ops[i].data);
            OP_EXPANDER: begin
               @(negedge clk);
               expander_present = ops[i].data[3:0];
            end
            OP_STREAM_RD: begin
               fork
                  load_stream(4);
                  cpu_access(ops[i], got);
               join
            end
            default:     cpu_access(ops[i], got);
         endcase
         if (ops[i].op inside {OP_IO_RD, OP_MEM_RD, OP_STREAM_RD})
            check_value("cpu_din", got, ops[i].exp_data);
      end

      $display("all tests passed");
      $finish;
   end

endmodule

/* src/msx_slot_system.sv */
`timescale 1ns/1ps

module msx_slot_system #(
   parameter int ADDR_W = 20
) (
   input  logic                                     clk,
   input  logic                                     clk_ce,
   input  logic                                     reset,
   input  logic [15:0]                              cpu_addr,
   input  logic [7:0]                               cpu_dout,
   input  logic                                     cpu_mreq,
   input  logic                                     cpu_iorq,
   input  logic                                     cpu_wr,
   output logic [7:0]                               cpu_din,
   output logic                                     cpu_ready,
   input  logic [ADDR_W-1:0]                        load_addr,
   input  logic [7:0]                               load_data,
   input  logic                                     load_req,
   output logic                                     load_done,
   input  logic                                     layout_we,
   input  logic [5:0]                               layout_index,
   input  msx_pkg::block_kind_t                     layout_kind,
   input  logic [ADDR_W-msx_pkg::PAGE_OFFSET_W-1:0] layout_base,
   input  logic [3:0]                               expander_present
);

   // Decoder to mapper
   logic                              map_strobe;
   logic [1:0]                        map_slot;
   logic [1:0]                        map_subslot;
   logic [1:0]                        map_page;
   logic [msx_pkg::PAGE_OFFSET_W-1:0] map_offset;
   logic                              map_wr;
   logic [7:0]                        map_wdata;
   logic                              map_ready;
   logic [7:0]                        map_rdata;

   // CPU channel of the arbiter
   logic                              cpu_mem_req;
   logic [ADDR_W-1:0]                 cpu_mem_addr;
   logic                              cpu_mem_wr;
   logic [7:0]                        cpu_mem_wdata;
   logic                              cpu_mem_done;
   logic [7:0]                        cpu_mem_rdata;

   // Shared memory port
   logic                              ram_req;
   logic [ADDR_W-1:0]                 ram_addr;
   logic                              ram_wr;
   logic [7:0]                        ram_wdata;
   logic [7:0]                        ram_rdata;
   logic                              ram_done;

   slot_decoder u_slot_decoder (
      .clk              (clk),
      .clk_ce           (clk_ce),
      .reset            (reset),
      .cpu_addr         (cpu_addr),
      .cpu_dout         (cpu_dout),
      .cpu_mreq         (cpu_mreq),
      .cpu_iorq         (cpu_iorq),
      .cpu_wr           (cpu_wr),
      .expander_present (expander_present),
      .map_ready        (map_ready),
      .map_rdata        (map_rdata),
      .cpu_mem_done     (cpu_mem_done),
      .cpu_mem_rdata    (cpu_mem_rdata),
      .cpu_din          (cpu_din),
      .cpu_ready        (cpu_ready),
      .map_strobe       (map_strobe),
      .map_slot         (map_slot),
      .map_subslot      (map_subslot),
      .map_page         (map_page),
      .map_offset       (map_offset),
      .map_wr           (map_wr),
      .map_wdata        (map_wdata)
   );

   block_mapper #(.ADDR_W(ADDR_W)) u_block_mapper (
      .clk           (clk),
      .reset         (reset),
      .layout_we     (layout_we),
      .layout_index  (layout_index),
      .layout_kind   (layout_kind),
      .layout_base   (layout_base),
      .map_strobe    (map_strobe),
      .map_slot      (map_slot),
      .map_subslot   (map_subslot),
      .map_page      (map_page),
      .map_offset    (map_offset),
      .map_wr        (map_wr),
      .map_wdata     (map_wdata),
      .map_ready     (map_ready),
      .map_rdata     (map_rdata),
      .cpu_mem_req   (cpu_mem_req),
      .cpu_mem_addr  (cpu_mem_addr),
      .cpu_mem_wr    (cpu_mem_wr),
      .cpu_mem_wdata (cpu_mem_wdata)
   );

   mem_arbiter #(.ADDR_W(ADDR_W)) u_mem_arbiter (
      .clk           (clk),
      .reset         (reset),
      .cpu_mem_req   (cpu_mem_req),
      .cpu_mem_addr  (cpu_mem_addr),
      .cpu_mem_wr    (cpu_mem_wr),
      .cpu_mem_wdata (cpu_mem_wdata),
      .load_req      (load_req),
      .load_addr     (load_addr),
      .load_data     (load_data),
      .ram_rdata     (ram_rdata),
      .ram_done      (ram_done),
      .cpu_mem_done  (cpu_mem_done),
      .cpu_mem_rdata (cpu_mem_rdata),
      .load_done     (load_done),
      .ram_req       (ram_req),
      .ram_addr      (ram_addr),
      .ram_wr        (ram_wr),
      .ram_wdata     (ram_wdata)
   );

   ram_store #(.ADDR_W(ADDR_W)) u_ram_store (
      .clk       (clk),
      .ram_req   (ram_req),
      .ram_addr  (ram_addr),
      .ram_wr    (ram_wr),
      .ram_wdata (ram_wdata),
      .ram_rdata (ram_rdata),
      .ram_done  (ram_done)
   );

endmodule

/* src/ram_store.sv */
`timescale 1ns/1ps

module ram_store #(
   parameter int ADDR_W = 20
) (
   input  logic              clk,
   input  logic              ram_req,
   input  logic [ADDR_W-1:0] ram_addr,
   input  logic              ram_wr,
   input  logic [7:0]        ram_wdata,
   output logic [7:0]        ram_rdata,
   output logic              ram_done
);

   logic [7:0] mem [2**ADDR_W];          // Byte wide, one port

   always_ff @(posedge clk) begin
      ram_done <= ram_req;               // Fixed one cycle turnaround
   end

   always_ff @(posedge clk) begin
      if (ram_req) begin
         if (ram_wr)
            mem[ram_addr] <= ram_wdata;
         else
            ram_rdata <= mem[ram_addr];  // Valid together with ram_done
      end
   end

endmodule

/* src/mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter #(
   parameter int ADDR_W = 20
) (
   input  logic              clk,
   input  logic              reset,
   input  logic              cpu_mem_req,
   input  logic [ADDR_W-1:0] cpu_mem_addr,
   input  logic              cpu_mem_wr,
   input  logic [7:0]        cpu_mem_wdata,
   input  logic              load_req,
   input  logic [ADDR_W-1:0] load_addr,
   input  logic [7:0]        load_data,
   input  logic [7:0]        ram_rdata,
   input  logic              ram_done,
   output logic              cpu_mem_done,
   output logic [7:0]        cpu_mem_rdata,
   output logic              load_done,
   output logic              ram_req,
   output logic [ADDR_W-1:0] ram_addr,
   output logic              ram_wr,
   output logic [7:0]        ram_wdata
);

   typedef enum logic [1:0] {
      ARB_IDLE,
      ARB_CPU_BUSY,
      ARB_LOAD_BUSY
   } arb_state_t;

   arb_state_t        state;
   logic              cpu_pending;       // CPU request still waiting for the port
   logic              load_done_q;
   logic [ADDR_W-1:0] cpu_addr_q;
   logic              cpu_wr_q;
   logic [7:0]        cpu_wdata_q;
   logic              start_cpu;
   logic              start_load;

   assign start_cpu  = (state == ARB_IDLE) && (cpu_mem_req || cpu_pending);

   // Loader drops load_req a cycle late, so skip the cycle after load_done
   assign start_load = (state == ARB_IDLE) && !start_cpu && load_req && !load_done_q;

   assign cpu_mem_done  = ram_done && (state == ARB_CPU_BUSY);
   assign load_done     = ram_done && (state == ARB_LOAD_BUSY);
   assign cpu_mem_rdata = ram_rdata;

   always_ff @(posedge clk) begin
      if (reset) begin
         state       <= ARB_IDLE;
         cpu_pending <= 1'b0;
         load_done_q <= 1'b0;
         ram_req     <= 1'b0;
      end else begin
         ram_req     <= start_cpu || start_load;
         load_done_q <= load_done;
         if (start_cpu)
            cpu_pending <= 1'b0;
         else if (cpu_mem_req)
            cpu_pending <= 1'b1;
         case (state)
            ARB_IDLE: begin
               if (start_cpu)
                  state <= ARB_CPU_BUSY;
               else if (start_load)
                  state <= ARB_LOAD_BUSY;
            end
            default: begin
               if (ram_done)
                  state <= ARB_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (cpu_mem_req) begin
         cpu_addr_q  <= cpu_mem_addr;
         cpu_wr_q    <= cpu_mem_wr;
         cpu_wdata_q <= cpu_mem_wdata;
      end
      if (start_cpu) begin
         ram_addr  <= cpu_mem_req ? cpu_mem_addr : cpu_addr_q;
         ram_wr    <= cpu_mem_req ? cpu_mem_wr : cpu_wr_q;
         ram_wdata <= cpu_mem_req ? cpu_mem_wdata : cpu_wdata_q;
      end else if (start_load) begin
         ram_addr  <= load_addr;
         ram_wr    <= 1'b1;                  // Loader only fills memory
         ram_wdata <= load_data;
      end
   end

   // One access outstanding, and the store answers on the next cycle
   a_one_cpu_request: assert property (@(posedge clk) disable iff (reset)
      cpu_mem_req |-> !cpu_pending)
      else $error("CPU request arrived while another one was still pending");

   a_done_follows_req: assert property (@(posedge clk) disable iff (reset)
      ram_req |=> ram_done)
      else $error("ram_done missing one cycle after ram_req");

endmodule

/* src/block_mapper.sv */
`timescale 1ns/1ps

module block_mapper #(
   parameter int ADDR_W = 20
) (
   input  logic                                     clk,
   input  logic                                     reset,
   input  logic                                     layout_we,
   input  logic [5:0]                               layout_index,
   input  msx_pkg::block_kind_t                     layout_kind,
   input  logic [ADDR_W-msx_pkg::PAGE_OFFSET_W-1:0] layout_base,
   input  logic                                     map_strobe,
   input  logic [1:0]                               map_slot,
   input  logic [1:0]                               map_subslot,
   input  logic [1:0]                               map_page,
   input  logic [msx_pkg::PAGE_OFFSET_W-1:0]        map_offset,
   input  logic                                     map_wr,
   input  logic [7:0]                               map_wdata,
   output logic                                     map_ready,
   output logic [7:0]                               map_rdata,
   output logic                                     cpu_mem_req,
   output logic [ADDR_W-1:0]                        cpu_mem_addr,
   output logic                                     cpu_mem_wr,
   output logic [7:0]                               cpu_mem_wdata
);

   localparam int BASE_W = ADDR_W - msx_pkg::PAGE_OFFSET_W;

   msx_pkg::block_kind_t kind_tab [msx_pkg::LAYOUT_ENTRIES];
   logic [BASE_W-1:0]    base_tab [msx_pkg::LAYOUT_ENTRIES];   // Base page in external memory
   logic [5:0]           index;
   msx_pkg::block_kind_t kind;
   logic                 to_memory;

   assign index = {map_slot, map_subslot, map_page};
   assign kind  = kind_tab[index];

   // ROM writes are dropped here so the image stays intact
   assign to_memory = (kind == msx_pkg::BLOCK_RAM) ||
                      (kind == msx_pkg::BLOCK_ROM && !map_wr);

   assign map_rdata = 8'hFF;             // Open bus value of an empty block

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < msx_pkg::LAYOUT_ENTRIES; i++)
            kind_tab[i] <= msx_pkg::BLOCK_NONE;
      end else if (layout_we) begin
         kind_tab[layout_index] <= layout_kind;
      end
   end

   always_ff @(posedge clk) begin
      if (layout_we)
         base_tab[layout_index] <= layout_base;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         map_ready   <= 1'b0;
         cpu_mem_req <= 1'b0;
      end else begin
         map_ready   <= map_strobe && !to_memory;
         cpu_mem_req <= map_strobe && to_memory;
      end
   end

   always_ff @(posedge clk) begin
      if (map_strobe) begin
         cpu_mem_addr  <= {base_tab[index], map_offset};
         cpu_mem_wr    <= map_wr;
         cpu_mem_wdata <= map_wdata;
      end
   end

   // Decoder sends no new cycle while the last one is being answered
   a_strobe_when_quiet: assert property (@(posedge clk) disable iff (reset)
      map_strobe |-> !map_ready && !cpu_mem_req)
      else $error("map_strobe arrived while the previous cycle was still being answered");

endmodule

/* src/slot_decoder.sv */
`timescale 1ns/1ps

module slot_decoder (
   input  logic                              clk,
   input  logic                              clk_ce,
   input  logic                              reset,
   input  logic [15:0]                       cpu_addr,
   input  logic [7:0]                        cpu_dout,
   input  logic                              cpu_mreq,
   input  logic                              cpu_iorq,
   input  logic                              cpu_wr,
   input  logic [3:0]                        expander_present,
   input  logic                              map_ready,
   input  logic [7:0]                        map_rdata,
   input  logic                              cpu_mem_done,
   input  logic [7:0]                        cpu_mem_rdata,
   output logic [7:0]                        cpu_din,
   output logic                              cpu_ready,
   output logic                              map_strobe,
   output logic [1:0]                        map_slot,
   output logic [1:0]                        map_subslot,
   output logic [1:0]                        map_page,
   output logic [msx_pkg::PAGE_OFFSET_W-1:0] map_offset,
   output logic                              map_wr,
   output logic [7:0]                        map_wdata
);

   logic [7:0]       slot_reg;           // Port A8h, two bits per page
   logic [7:0]       subslot_reg [4];    // FFFFh register of each primary slot
   logic             busy;
   logic             reg_ack;
   logic [7:0]       reg_rdata;
   logic             cpu_cycle;
   logic             strobe;
   logic [1:0]       page;
   logic [1:0]       active_slot;
   logic [1:0]       active_subslot;
   logic [1:0]       page3_slot;         // Slot that owns the FFFFh register
   msx_pkg::access_t access;

   assign cpu_cycle   = clk_ce && (cpu_mreq || cpu_iorq);
   assign strobe      = cpu_cycle && !busy;
   assign page        = cpu_addr[15:14];
   assign active_slot = slot_reg[page*2 +: 2];
   assign page3_slot  = slot_reg[7:6];

   // Slots without an expander always sit on subslot 0
   assign active_subslot = expander_present[active_slot] ?
                           subslot_reg[active_slot][page*2 +: 2] : 2'd0;

   always_comb begin
      access = msx_pkg::ACC_IDLE;
      if (cpu_iorq) begin
         if (cpu_addr[7:0] == 8'hA8)
            access = msx_pkg::ACC_PORT_A8;
      end else if (cpu_mreq) begin
         if (cpu_addr == 16'hFFFF && expander_present[page3_slot])
            access = msx_pkg::ACC_SUBSLOT;
         else
            access = msx_pkg::ACC_MEM;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         slot_reg   <= 8'h00;
         busy       <= 1'b0;
         reg_ack    <= 1'b0;
         map_strobe <= 1'b0;
         for (int i = 0; i < 4; i++)
            subslot_reg[i] <= 8'h00;
      end else begin
         reg_ack    <= strobe && (access != msx_pkg::ACC_MEM);  // Own answer, one cycle
         map_strobe <= strobe && (access == msx_pkg::ACC_MEM);
         if (strobe)
            busy <= 1'b1;
         else if (cpu_ready)
            busy <= 1'b0;
         if (strobe && cpu_wr) begin
            if (access == msx_pkg::ACC_PORT_A8)
               slot_reg <= cpu_dout;
            if (access == msx_pkg::ACC_SUBSLOT)
               subslot_reg[page3_slot] <= cpu_dout;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (strobe) begin
         map_slot    <= active_slot;
         map_subslot <= active_subslot;
         map_page    <= page;
         map_offset  <= cpu_addr[msx_pkg::PAGE_OFFSET_W-1:0];
         map_wr      <= cpu_wr;
         map_wdata   <= cpu_dout;
         case (access)
            msx_pkg::ACC_PORT_A8: reg_rdata <= slot_reg;
            msx_pkg::ACC_SUBSLOT: reg_rdata <= ~subslot_reg[page3_slot];  // Reads back inverted
            default:              reg_rdata <= 8'hFF;                     // Unused I/O port
         endcase
      end
   end

   assign cpu_ready = reg_ack || map_ready || cpu_mem_done;
   assign cpu_din   = reg_ack   ? reg_rdata :
                      map_ready ? map_rdata : cpu_mem_rdata;

   // The CPU must wait for cpu_ready before the next cycle
   a_no_cycle_while_busy: assert property (@(posedge clk) disable iff (reset)
      busy |-> !cpu_cycle)
      else $error("CPU cycle started before cpu_ready");

endmodule

/* src/msx_pkg.sv */
package msx_pkg;

   // Offset inside one 16 KB page
   localparam int PAGE_OFFSET_W = 14;

   // Slot, subslot and page give 2 + 2 + 2 index bits
   localparam int LAYOUT_ENTRIES = 64;

   // Contents of one 16 KB block in the slot layout
   typedef enum logic [1:0] {
      BLOCK_NONE,                        // Nothing mapped, reads FFh
      BLOCK_ROM,                         // Read only image in external memory
      BLOCK_RAM                          // Read/write area in external memory
   } block_kind_t;

   // Class of the current CPU bus cycle
   typedef enum logic [1:0] {
      ACC_IDLE,                          // No cycle, or an I/O port nobody owns
      ACC_PORT_A8,                       // Primary slot register
      ACC_SUBSLOT,                       // Expander register at FFFFh
      ACC_MEM                            // Memory cycle through the layout table
   } access_t;

endpackage
